// File: vcache_pkg.sv
// shared opcodes, decode fields and profiler select codes
// imported by the cache core, the decoder, the profiler and the monitor interface
`default_nettype none

package vcache_pkg;

  localparam int data_width_c = 32;
  localparam int mask_width_c = 4;

  // access size field of the decode struct
  localparam logic [1:0] size_byte_c = 2'd0;
  localparam logic [1:0] size_half_c = 2'd1;
  localparam logic [1:0] size_word_c = 2'd2;

  typedef enum logic [3:0] {
    LW    = 4'd0,
    LH    = 4'd1,
    LHU   = 4'd2,
    LB    = 4'd3,
    LBU   = 4'd4,
    SW    = 4'd5,
    SH    = 4'd6,
    SB    = 4'd7,
    TAGFL = 4'd8
  } vcache_op_e;

  typedef struct packed {
    logic       ld_op;
    logic       st_op;
    logic       tagfl_op;
    logic [1:0] size;
    logic       sigext_op;
  } vcache_decode_s;

  // per-opcode codes share their value with the opcode
  typedef enum logic [4:0] {
    STAT_LW          = 5'd0,
    STAT_LH          = 5'd1,
    STAT_LHU         = 5'd2,
    STAT_LB          = 5'd3,
    STAT_LBU         = 5'd4,
    STAT_SW          = 5'd5,
    STAT_SH          = 5'd6,
    STAT_SB          = 5'd7,
    STAT_TAGFL       = 5'd8,
    STAT_LD          = 5'd9,
    STAT_ST          = 5'd10,
    STAT_LD_MISS     = 5'd11,
    STAT_ST_MISS     = 5'd12,
    STAT_MISS_CYCLES = 5'd13,
    STAT_IDLE_CYCLES = 5'd14,
    STAT_DMA_READ    = 5'd15,
    STAT_DMA_WRITE   = 5'd16
  } stat_sel_e;

  localparam int stat_num_c = 17;

endpackage

`default_nettype wire

// File: vcache_mon_if.sv
// cache events seen by the profiler
// driven by the core through mon_src, read by the profiler through mon_sink
`timescale 1ns/1ps
`default_nettype none

interface vcache_mon_if;
  import vcache_pkg::*;

  logic           resp_v;
  logic           resp_yumi;
  logic           miss_busy;
  vcache_decode_s decode;
  vcache_op_e     op;
  logic           dma_rd_fire;
  logic           dma_wr_fire;

  modport mon_src (
    output resp_v, resp_yumi, miss_busy, decode, op, dma_rd_fire, dma_wr_fire
  );

  modport mon_sink (
    input resp_v, resp_yumi, miss_busy, decode, op, dma_rd_fire, dma_wr_fire
  );

endinterface

`default_nettype wire

// File: vcache_decode.sv
// opcode decoder for the cache core
`timescale 1ns/1ps
`default_nettype none

module vcache_decode (
  input  vcache_pkg::vcache_op_e     op_i,
  output vcache_pkg::vcache_decode_s decode_o
);
  import vcache_pkg::*;

  always_comb begin
    decode_o = '0;
    case (op_i)
      LW: begin
        decode_o.ld_op = 1'b1;
        decode_o.size  = size_word_c;
      end
      LH, LHU: begin
        decode_o.ld_op     = 1'b1;
        decode_o.size      = size_half_c;
        decode_o.sigext_op = (op_i == LH);
      end
      LB, LBU: begin
        decode_o.ld_op     = 1'b1;
        decode_o.size      = size_byte_c;
        decode_o.sigext_op = (op_i == LB);
      end
      SW: begin
        decode_o.st_op = 1'b1;
        decode_o.size  = size_word_c;
      end
      SH: begin
        decode_o.st_op = 1'b1;
        decode_o.size  = size_half_c;
      end
      SB: begin
        decode_o.st_op = 1'b1;
        decode_o.size  = size_byte_c;
      end
      TAGFL: decode_o.tagfl_op = 1'b1;
      default: decode_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: vcache_miss.sv
// miss and write-through handler, one DMA packet per request
`timescale 1ns/1ps
`default_nettype none

module vcache_miss #(
  parameter int addr_width_p = 12
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 start_i,
  input  logic                                 write_i,
  input  logic [addr_width_p-1:0]              addr_i,
  input  logic [vcache_pkg::data_width_c-1:0]  data_i,
  input  logic [vcache_pkg::mask_width_c-1:0]  mask_i,
  input  logic                                 dma_pkt_yumi_i,
  input  logic                                 dma_data_v_i,
  input  logic [vcache_pkg::data_width_c-1:0]  dma_data_i,
  output logic                                 dma_pkt_v_o,
  output logic                                 dma_pkt_write_o,
  output logic [addr_width_p-1:0]              dma_pkt_addr_o,
  output logic [vcache_pkg::data_width_c-1:0]  dma_pkt_data_o,
  output logic [vcache_pkg::mask_width_c-1:0]  dma_pkt_mask_o,
  output logic                                 busy_o,
  output logic                                 done_o,
  output logic [vcache_pkg::data_width_c-1:0]  fill_data_o,
  output logic                                 dma_rd_fire_o,
  output logic                                 dma_wr_fire_o
);
  import vcache_pkg::*;

  typedef enum logic [1:0] {IDLE, SEND, WAIT} state_e;

  state_e                   state_r;
  logic                     write_r;
  logic [addr_width_p-1:0]  addr_r;
  logic [data_width_c-1:0]  data_r;
  logic [mask_width_c-1:0]  mask_r;
  logic [data_width_c-1:0]  fill_r;
  logic                     pkt_fire;
  logic                     fill_fire;

  assign pkt_fire  = dma_pkt_v_o & dma_pkt_yumi_i;
  assign fill_fire = (state_r == WAIT) & dma_data_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
    end else begin
      case (state_r)
        IDLE: if (start_i) state_r <= SEND;
        SEND: if (pkt_fire) state_r <= write_r ? IDLE : WAIT;
        WAIT: if (fill_fire) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && state_r == IDLE) begin
      write_r <= write_i;
      addr_r  <= addr_i;
      data_r  <= data_i;
      mask_r  <= mask_i;
    end
    if (fill_fire) fill_r <= dma_data_i;
  end

  assign dma_pkt_v_o     = (state_r == SEND);
  assign dma_pkt_write_o = write_r;
  assign dma_pkt_addr_o  = addr_r;
  assign dma_pkt_data_o  = data_r;
  assign dma_pkt_mask_o  = mask_r;

  assign busy_o = (state_r != IDLE);
  assign done_o = (pkt_fire & write_r) | fill_fire;
  // bypass in the fill cycle so the core can respond next cycle
  assign fill_data_o = fill_fire ? dma_data_i : fill_r;

  assign dma_rd_fire_o = pkt_fire & ~write_r;
  assign dma_wr_fire_o = pkt_fire & write_r;

  // packet held under back-pressure
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_pkt_v_o && !dma_pkt_yumi_i |=> dma_pkt_v_o && $stable(dma_pkt_addr_o)
      && $stable(dma_pkt_data_o) && $stable(dma_pkt_mask_o) && $stable(dma_pkt_write_o));

endmodule

`default_nettype wire

// File: vcache_core.sv
// direct-mapped write-through cache, one word per line, one request at a time
// misses and stores go out through the miss handler
`timescale 1ns/1ps
`default_nettype none

module vcache_core #(
  parameter int addr_width_p = 12,
  parameter int sets_p       = 16
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                v_i,
  input  vcache_pkg::vcache_op_e              op_i,
  input  logic [addr_width_p-1:0]             addr_i,
  input  logic [vcache_pkg::data_width_c-1:0] data_i,
  output logic                                ready_o,
  output logic                                v_o,
  output logic [vcache_pkg::data_width_c-1:0] data_o,
  input  logic                                yumi_i,
  output logic                                dma_pkt_v_o,
  output logic                                dma_pkt_write_o,
  output logic [addr_width_p-1:0]             dma_pkt_addr_o,
  output logic [vcache_pkg::data_width_c-1:0] dma_pkt_data_o,
  output logic [vcache_pkg::mask_width_c-1:0] dma_pkt_mask_o,
  input  logic                                dma_pkt_yumi_i,
  input  logic                                dma_data_v_i,
  input  logic [vcache_pkg::data_width_c-1:0] dma_data_i,
  vcache_mon_if.mon_src                       mon
);
  import vcache_pkg::*;

  localparam int idx_width_lp = $clog2(sets_p);
  localparam int tag_width_lp = addr_width_p - 2 - idx_width_lp;

  function automatic logic [data_width_c-1:0] load_extract(
    input logic [data_width_c-1:0] word,
    input logic [1:0]              off,
    input vcache_decode_s          d
  );
    logic [7:0]              b;
    logic [15:0]             h;
    logic [data_width_c-1:0] res;
    b = word[8*off +: 8];
    h = word[16*off[1] +: 16];
    case (d.size)
      size_byte_c: res = {{24{d.sigext_op & b[7]}}, b};
      size_half_c: res = {{16{d.sigext_op & h[15]}}, h};
      default:     res = word;
    endcase
    return res;
  endfunction

  logic [sets_p-1:0]        valid_r;
  logic [tag_width_lp-1:0]  tag_mem [sets_p];
  logic [data_width_c-1:0]  data_mem [sets_p];

  vcache_op_e               req_op_r;
  logic [addr_width_p-1:0]  req_addr_r;
  vcache_decode_s           decode_r;
  logic [data_width_c-1:0]  data_r;
  logic                     busy_r;
  logic                     v_r;
  logic                     missed_r;

  vcache_decode_s           dec;
  logic [idx_width_lp-1:0]  acc_idx;
  logic [idx_width_lp-1:0]  req_idx;
  logic                     hit;
  logic                     accept;
  logic                     start;
  logic [data_width_c-1:0]  st_word;
  logic [mask_width_c-1:0]  st_mask;
  logic [data_width_c-1:0]  merged;
  logic                     miss_busy;
  logic                     miss_done;
  logic [data_width_c-1:0]  fill_data;

  vcache_decode decode (
    .op_i     (op_i),
    .decode_o (dec)
  );

  assign acc_idx = addr_i[2 +: idx_width_lp];
  assign req_idx = req_addr_r[2 +: idx_width_lp];
  assign hit     = valid_r[acc_idx] & (tag_mem[acc_idx] == addr_i[addr_width_p-1 -: tag_width_lp]);
  assign accept  = v_i & ready_o;
  assign start   = accept & (dec.st_op | (dec.ld_op & ~hit));

  // lane-aligned store data and byte mask
  always_comb begin
    case (dec.size)
      size_byte_c: begin
        st_word = {4{data_i[7:0]}};
        st_mask = mask_width_c'(1) << addr_i[1:0];
      end
      size_half_c: begin
        st_word = {2{data_i[15:0]}};
        st_mask = addr_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        st_word = data_i;
        st_mask = '1;
      end
    endcase
    for (int i = 0; i < mask_width_c; i++) begin
      merged[8*i +: 8] = st_mask[i] ? st_word[8*i +: 8] : data_mem[acc_idx][8*i +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r   <= 1'b0;
      v_r      <= 1'b0;
      missed_r <= 1'b0;
      valid_r  <= '0;
    end else if (accept) begin
      busy_r   <= 1'b1;
      v_r      <= ~start;
      missed_r <= (dec.ld_op | dec.st_op) & ~hit;
      if (dec.tagfl_op) valid_r[acc_idx] <= 1'b0;
    end else if (miss_done) begin
      v_r <= 1'b1;
      if (decode_r.ld_op) valid_r[req_idx] <= 1'b1;
    end else if (v_r & yumi_i) begin
      v_r    <= 1'b0;
      busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_op_r   <= op_i;
      req_addr_r <= addr_i;
      decode_r   <= dec;
      data_r     <= (dec.ld_op & hit) ? load_extract(data_mem[acc_idx], addr_i[1:0], dec) : '0;
      if (dec.st_op & hit) data_mem[acc_idx] <= merged;
    end
    if (miss_done & decode_r.ld_op) begin
      tag_mem[req_idx]  <= req_addr_r[addr_width_p-1 -: tag_width_lp];
      data_mem[req_idx] <= fill_data;
      data_r            <= load_extract(fill_data, req_addr_r[1:0], decode_r);
    end
  end

  vcache_miss #(.addr_width_p(addr_width_p)) miss (
    .clk_i, .reset_i,
    .start_i         (start),
    .write_i         (dec.st_op),
    .addr_i          ({addr_i[addr_width_p-1:2], 2'b00}),
    .data_i          (st_word),
    .mask_i          (st_mask),
    .dma_pkt_yumi_i, .dma_data_v_i, .dma_data_i,
    .dma_pkt_v_o, .dma_pkt_write_o, .dma_pkt_addr_o, .dma_pkt_data_o, .dma_pkt_mask_o,
    .busy_o          (miss_busy),
    .done_o          (miss_done),
    .fill_data_o     (fill_data),
    .dma_rd_fire_o   (mon.dma_rd_fire),
    .dma_wr_fire_o   (mon.dma_wr_fire)
  );

  assign ready_o = ~busy_r;
  assign v_o     = v_r;
  assign data_o  = data_r;

  // store hits keep the handler busy without counting as a miss
  assign mon.miss_busy = miss_busy & missed_r;
  assign mon.resp_v    = v_r;
  assign mon.resp_yumi = yumi_i;
  assign mon.decode    = decode_r;
  assign mon.op        = req_op_r;

  assert property (@(posedge clk_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(data_o));

  assert property (@(posedge clk_i) disable iff (reset_i)
    busy_r |-> !(decode_r.ld_op && decode_r.st_op));

endmodule

`default_nettype wire

// File: vcache_profiler.sv
// event counters beside the cache, read back through a select port
`timescale 1ns/1ps
`default_nettype none

module vcache_profiler #(
  parameter int stat_width_p = 32
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    stat_clear_i,
  input  vcache_pkg::stat_sel_e   stat_sel_i,
  vcache_mon_if.mon_sink          mon,
  output logic [stat_width_p-1:0] stat_o
);
  import vcache_pkg::*;

  logic [stat_width_p-1:0] cnt_r [stat_num_c];
  logic [stat_num_c-1:0]   inc;
  logic                    fire;
  logic                    any_op;
  logic                    miss_seen_r;

  assign fire   = mon.resp_v & mon.resp_yumi;
  assign any_op = mon.decode.ld_op | mon.decode.st_op | mon.decode.tagfl_op;

  // remembers a miss until its response fires
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_seen_r <= 1'b0;
    end else if (fire) begin
      miss_seen_r <= 1'b0;
    end else if (mon.miss_busy) begin
      miss_seen_r <= 1'b1;
    end
  end

  always_comb begin
    inc = '0;
    if (fire && any_op) inc[mon.op] = 1'b1;
    inc[STAT_LD]          = fire & mon.decode.ld_op;
    inc[STAT_ST]          = fire & mon.decode.st_op;
    inc[STAT_LD_MISS]     = fire & mon.decode.ld_op & miss_seen_r;
    inc[STAT_ST_MISS]     = fire & mon.decode.st_op & miss_seen_r;
    inc[STAT_MISS_CYCLES] = mon.miss_busy;
    inc[STAT_IDLE_CYCLES] = ~fire & ~mon.miss_busy;
    inc[STAT_DMA_READ]    = mon.dma_rd_fire;
    inc[STAT_DMA_WRITE]   = mon.dma_wr_fire;
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < stat_num_c; i++) begin
      if (reset_i || stat_clear_i) begin
        cnt_r[i] <= '0;
      end else if (inc[i]) begin
        cnt_r[i] <= cnt_r[i] + stat_width_p'(1);
      end
    end
  end

  assign stat_o = (int'(stat_sel_i) < stat_num_c) ? cnt_r[stat_sel_i] : '0;

  // the handler finishes before the response can be taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(mon.miss_busy && fire));

endmodule

`default_nettype wire

// File: vcache_top.sv
// profiled data cache top level with plain request, response, DMA and stat ports
// sets the cache parameters for the core and the profiler
`timescale 1ns/1ps
`default_nettype none

module vcache_top #(
  parameter int addr_width_p = 12,
  parameter int sets_p       = 16,
  parameter int stat_width_p = 32
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                v_i,
  output logic                                ready_o,
  input  vcache_pkg::vcache_op_e              op_i,
  input  logic [addr_width_p-1:0]             addr_i,
  input  logic [vcache_pkg::data_width_c-1:0] data_i,
  output logic                                v_o,
  output logic [vcache_pkg::data_width_c-1:0] data_o,
  input  logic                                yumi_i,
  output logic                                dma_pkt_v_o,
  output logic                                dma_pkt_write_o,
  output logic [addr_width_p-1:0]             dma_pkt_addr_o,
  output logic [vcache_pkg::data_width_c-1:0] dma_pkt_data_o,
  output logic [vcache_pkg::mask_width_c-1:0] dma_pkt_mask_o,
  input  logic                                dma_pkt_yumi_i,
  input  logic                                dma_data_v_i,
  input  logic [vcache_pkg::data_width_c-1:0] dma_data_i,
  input  logic                                stat_clear_i,
  input  vcache_pkg::stat_sel_e               stat_sel_i,
  output logic [stat_width_p-1:0]             stat_o
);

  vcache_mon_if mon ();

  vcache_core #(
    .addr_width_p (addr_width_p),
    .sets_p       (sets_p)
  ) core (
    .clk_i, .reset_i, .v_i, .op_i, .addr_i, .data_i, .ready_o,
    .v_o, .data_o, .yumi_i,
    .dma_pkt_v_o, .dma_pkt_write_o, .dma_pkt_addr_o, .dma_pkt_data_o, .dma_pkt_mask_o,
    .dma_pkt_yumi_i, .dma_data_v_i, .dma_data_i,
    .mon          (mon.mon_src)
  );

  vcache_profiler #(.stat_width_p(stat_width_p)) profiler (
    .clk_i, .reset_i, .stat_clear_i, .stat_sel_i,
    .mon          (mon.mon_sink),
    .stat_o
  );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// clock and reset source for the cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int period_p       = 100,
  parameter int reset_cycles_p = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: vcache_tb.sv
// testbench for the profiled data cache
// runs a request table against a DMA memory model, then reads back the profiler counters
`timescale 1ns/1ps
`default_nettype none

module vcache_tb;
  import vcache_pkg::*;

  // memory word at byte address a holds a * fill_mult_c
  localparam logic [31:0] fill_mult_c = 32'h0100_0003;
  // every counter has counted something before this row
  localparam int clear_row_c = 13;

  logic        clk;
  logic        reset;
  logic        req_v = 1'b0;
  vcache_op_e  req_op = LW;
  logic [11:0] req_addr = '0;
  logic [31:0] req_data = '0;
  logic        resp_yumi = 1'b0;
  logic        pkt_yumi = 1'b0;
  logic        fill_v = 1'b0;
  logic [31:0] fill_data = '0;
  logic        stat_clear = 1'b0;
  stat_sel_e   stat_sel = STAT_LW;
  logic        ready;
  logic        resp_v;
  logic [31:0] resp_data;
  logic        pkt_v;
  logic        pkt_write;
  logic [11:0] pkt_addr;
  logic [31:0] pkt_data;
  logic [3:0]  pkt_mask;
  logic [31:0] stat;

  // request table
  string       name_q [$];
  vcache_op_e  op_q [$];
  logic [11:0] addr_q [$];
  logic [31:0] wdata_q [$];
  int          dly_q [$];
  logic [31:0] exp_q [$];

  // memory model and packet record
  logic [31:0] mem [1024];
  int          rd_cnt;
  int          wr_cnt;
  int          fill_wait;
  logic [11:0] rd_addr;
  logic [11:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_mask;

  // expected cache contents and counter tallies
  logic [15:0] line_valid = '0;
  logic [5:0]  line_tag [16];
  int          exp_stat [stat_num_c];
  logic        row_miss = 1'b0;
  logic        busy_mdl = 1'b0;
  int          cycles;
  int          miss_cyc;
  int          idle_cyc;

  tb_clkgen clkgen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  vcache_top uut (
    .clk_i           (clk),
    .reset_i         (reset),
    .v_i             (req_v),
    .ready_o         (ready),
    .op_i            (req_op),
    .addr_i          (req_addr),
    .data_i          (req_data),
    .v_o             (resp_v),
    .data_o          (resp_data),
    .yumi_i          (resp_yumi),
    .dma_pkt_v_o     (pkt_v),
    .dma_pkt_write_o (pkt_write),
    .dma_pkt_addr_o  (pkt_addr),
    .dma_pkt_data_o  (pkt_data),
    .dma_pkt_mask_o  (pkt_mask),
    .dma_pkt_yumi_i  (pkt_yumi),
    .dma_data_v_i    (fill_v),
    .dma_data_i      (fill_data),
    .stat_clear_i    (stat_clear),
    .stat_sel_i      (stat_sel),
    .stat_o          (stat)
  );

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("tests failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic add_row(input string name, input vcache_op_e op, input logic [11:0] addr,
                         input logic [31:0] wdata, input int dly, input logic [31:0] exp);
    name_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    wdata_q.push_back(wdata);
    dly_q.push_back(dly);
    exp_q.push_back(exp);
  endtask

  function automatic logic [3:0] byte_mask(input vcache_op_e op, input logic [1:0] off);
    case (op)
      SB:      return 4'b0001 << off;
      SH:      return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // DMA memory, fill arrives 1 to 4 cycles after the read packet
  initial begin
    void'($urandom(63));
    forever begin
      @(posedge clk);
      pkt_yumi <= 1'b0;
      fill_v   <= 1'b0;
      if (!reset) begin
        if (pkt_v && pkt_yumi) begin
          if (pkt_write) begin
            for (int b = 0; b < 4; b++) begin
              if (pkt_mask[b]) mem[pkt_addr[11:2]][8*b +: 8] = pkt_data[8*b +: 8];
            end
            wr_cnt++;
            wr_addr = pkt_addr;
            wr_data = pkt_data;
            wr_mask = pkt_mask;
          end else begin
            rd_cnt++;
            rd_addr   = pkt_addr;
            fill_wait = int'($urandom % 4) + 1;
          end
        end else if (pkt_v) begin
          pkt_yumi <= 1'b1;
        end
        if (fill_wait > 0) begin
          fill_wait--;
          if (fill_wait == 0) begin
            fill_v    <= 1'b1;
            fill_data <= mem[rd_addr[11:2]];
          end
        end
      end
    end
  end

  // cycle tallies since the last clear; busy_mdl tracks the miss handler
  always @(posedge clk) begin
    if (reset || stat_clear) begin
      cycles   = 0;
      miss_cyc = 0;
      idle_cyc = 0;
    end else begin
      cycles++;
      if (busy_mdl) miss_cyc++;
      if (!(resp_v && resp_yumi) && !busy_mdl) idle_cyc++;
    end
    if ((pkt_v && pkt_yumi && pkt_write) || fill_v) busy_mdl = 1'b0;
    if (req_v && ready && row_miss) busy_mdl = 1'b1;
  end

  task automatic run_row(input int r);
    logic [11:0] a;
    logic [31:0] got;
    logic [31:0] bytes;
    logic [3:0]  mask;
    vcache_op_e  op;
    string       nm;
    int          rd0;
    int          wr0;
    int          shift;
    logic        miss;
    logic        is_ld;
    logic        is_st;
    a     = addr_q[r];
    op    = op_q[r];
    nm    = name_q[r];
    rd0   = rd_cnt;
    wr0   = wr_cnt;
    is_ld = op inside {LW, LH, LHU, LB, LBU};
    is_st = op inside {SW, SH, SB};
    miss  = !(line_valid[a[5:2]] && line_tag[a[5:2]] == a[11:6]);
    row_miss = miss && (is_ld || is_st);
    @(posedge clk);
    req_v    <= 1'b1;
    req_op   <= op;
    req_addr <= a;
    req_data <= wdata_q[r];
    @(negedge clk);
    check_val({nm, " ready"}, 1, ready);
    @(posedge clk);
    req_v <= 1'b0;
    @(negedge clk);
    while (!resp_v) begin
      check_val({nm, " ready while busy"}, 0, ready);
      @(negedge clk);
    end
    got = resp_data;
    check_val(nm, exp_q[r], got);
    check_val({nm, " dma reads"}, (is_ld && miss) ? 1 : 0, 32'(rd_cnt - rd0));
    check_val({nm, " dma writes"}, is_st ? 1 : 0, 32'(wr_cnt - wr0));
    if (is_ld && miss) check_val({nm, " read addr"}, {a[11:2], 2'b00}, rd_addr);
    if (is_st) begin
      mask  = byte_mask(op, a[1:0]);
      shift = (op == SB) ? 8 * int'(a[1:0]) : (op == SH) ? 16 * int'(a[1]) : 0;
      bytes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
      check_val({nm, " write addr"}, {a[11:2], 2'b00}, wr_addr);
      check_val({nm, " write mask"}, mask, wr_mask);
      check_val({nm, " write data"}, (wdata_q[r] << shift) & bytes, wr_data & bytes);
    end
    for (int k = 0; k < dly_q[r]; k++) begin
      @(negedge clk);
      check_val({nm, " v_o held"}, 1, resp_v);
      check_val({nm, " data_o held"}, got, resp_data);
      check_val({nm, " ready held low"}, 0, ready);
    end
    @(posedge clk);
    resp_yumi <= 1'b1;
    @(posedge clk);
    resp_yumi <= 1'b0;
    @(negedge clk);
    check_val({nm, " v_o after yumi"}, 0, resp_v);
    check_val({nm, " ready after yumi"}, 1, ready);
    // no write allocate, loads fill the line
    if (is_ld && miss) begin
      line_valid[a[5:2]] = 1'b1;
      line_tag[a[5:2]]   = a[11:6];
    end
    if (op == TAGFL) line_valid[a[5:2]] = 1'b0;
    exp_stat[int'(op)]++;
    if (is_ld) exp_stat[STAT_LD]++;
    if (is_st) exp_stat[STAT_ST]++;
    if (is_ld && miss) exp_stat[STAT_LD_MISS]++;
    if (is_st && miss) exp_stat[STAT_ST_MISS]++;
    exp_stat[STAT_DMA_READ]  += rd_cnt - rd0;
    exp_stat[STAT_DMA_WRITE] += wr_cnt - wr0;
  endtask

  task automatic check_stats(input string phase);
    logic [31:0] miss_read;
    stat_sel_e   sel;
    int          fires;
    fires     = exp_stat[STAT_LD] + exp_stat[STAT_ST] + exp_stat[STAT_TAGFL];
    miss_read = '0;
    for (int s = 0; s < stat_num_c; s++) begin
      sel = stat_sel_e'(s);
      @(posedge clk);
      stat_sel <= sel;
      @(negedge clk);
      exp_stat[STAT_MISS_CYCLES] = miss_cyc;
      exp_stat[STAT_IDLE_CYCLES] = idle_cyc;
      check_val({phase, " ", sel.name()}, 32'(exp_stat[s]), stat);
      if (sel == STAT_MISS_CYCLES) miss_read = stat;
      if (sel == STAT_IDLE_CYCLES) begin
        check_val({phase, " cycle sum"}, 32'(cycles), stat + miss_read + 32'(fires));
      end
    end
  endtask

  // one cycle of clear, then every counter starts again from zero
  task automatic clear_stats();
    @(posedge clk);
    stat_clear <= 1'b1;
    @(posedge clk);
    stat_clear <= 1'b0;
    stat_sel   <= STAT_IDLE_CYCLES;
    @(negedge clk);
    check_val("idle after clear", 0, stat);
    for (int s = 0; s < stat_num_c; s++) begin
      exp_stat[s] = 0;
    end
    check_stats("after clear");
  endtask

  initial begin
    int limit;
    #1;
    limit = name_q.size() * 40;
    repeat (limit) @(posedge clk);
    $display("tests failed");
    $fatal(1, "the run timed out after %0d cycles", limit);
  end

  initial begin
    for (int w = 0; w < 1024; w++) begin
      mem[w] = 32'(w * 4) * fill_mult_c;
    end
    add_row("lw miss",        LW,    12'h084, 32'h0,        0, 32'h8400018c);
    add_row("lw hit",         LW,    12'h084, 32'h0,        2, 32'h8400018c);
    add_row("lb sign",        LB,    12'h084, 32'h0,        0, 32'hffffff8c);
    add_row("lbu zero",       LBU,   12'h087, 32'h0,        0, 32'h00000084);
    add_row("lh sign",        LH,    12'h086, 32'h0,        1, 32'hffff8400);
    add_row("lhu zero",       LHU,   12'h086, 32'h0,        0, 32'h00008400);
    add_row("sb hit",         SB,    12'h085, 32'h000000a5, 1, 32'h0);
    add_row("lw merged",      LW,    12'h084, 32'h0,        0, 32'h8400a58c);
    add_row("sh miss",        SH,    12'h0c6, 32'h00001234, 0, 32'h0);
    add_row("lw after sh",    LW,    12'h0c4, 32'h0,        0, 32'h1234024c);
    add_row("lw refill",      LW,    12'h084, 32'h0,        0, 32'h8400a58c);
    add_row("sw hit",         SW,    12'h084, 32'hdeadbeef, 0, 32'h0);
    add_row("tagfl",          TAGFL, 12'h084, 32'h0,        2, 32'h0);
    add_row("lw after tagfl", LW,    12'h084, 32'h0,        0, 32'hdeadbeef);
    add_row("lh miss",        LH,    12'h0f2, 32'h0,        3, 32'hfffff000);
    add_row("lb miss",        LB,    12'h048, 32'h0,        0, 32'hffffffd8);
    add_row("sb hit upper",   SB,    12'h0f3, 32'h0000007f, 0, 32'h0);
    add_row("lbu after sb",   LBU,   12'h0f3, 32'h0,        1, 32'h0000007f);
    add_row("sw miss",        SW,    12'h200, 32'h0badf00d, 0, 32'h0);
    add_row("lw after sw",    LW,    12'h200, 32'h0,        0, 32'h0badf00d);
    repeat (2) @(posedge clk);
    while (reset) @(posedge clk);
    @(negedge clk);
    check_val("v_o after reset", 0, resp_v);
    check_val("dma_pkt_v_o after reset", 0, pkt_v);
    for (int r = 0; r < name_q.size(); r++) begin
      if (r == clear_row_c) begin
        check_stats("before clear");
        clear_stats();
      end
      run_row(r);
    end
    check_stats("final");
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
vcache_pkg.sv
vcache_mon_if.sv
vcache_decode.sv
vcache_miss.sv
vcache_core.sv
vcache_profiler.sv
vcache_top.sv
tb_clkgen.sv
vcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and searches the log for the result
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module vcache_tb -o vcache_sim
./obj_dir/vcache_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "tests failed" sim.log; then
  echo "simulation FAILED"
  exit 1
elif ! grep -q "all tests passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation PASSED"
